/* verilog.f */
+incdir+.
acq_pkg.sv
multi_sampler.sv
acq_control.sv
decim_accum.sv
acq_top.sv
acq_properties.sv
acq_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the acquisition testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module acq_tb -f verilog.f -o acq_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/acq_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
   exit 0
fi
exit 1

/* acq_tb.sv */
`include "acq_consts.svh"

module acq_tb
   import acq_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_RUNS     = 20;
   localparam int RESET_CYCLES = 16;
   localparam int NUM_CH       = 3;

   logic     clk;
   logic     reset;
   logic     ext_trig;
   logic     start;
   logic     stop;
   count_t   capture_len;
   period_t  sample_period;
   dperiod_t dsample0_period;
   dperiod_t dsample1_period;
   dperiod_t dsample2_period;
   adc_t     adc_data;
   logic     sample_out;
   logic     busy;
   logic     done;
   sum_t     dec0_data;
   sum_t     dec1_data;
   sum_t     dec2_data;
   logic     dec0_valid;
   logic     dec1_valid;
   logic     dec2_valid;

   // Reference model state
   ctrl_state_t exp_state;
   int          exp_cnt;
   logic        exp_done;
   int          exp_per_r;            // Period registered at the last tick
   int          exp_base;
   logic        exp_sample;
   int          exp_ds [NUM_CH];
   int          exp_acc [NUM_CH];
   int          exp_data [NUM_CH];
   logic        exp_valid [NUM_CH];

   int   errors = 0;
   int   checks = 0;
   int   cycles = 0;
   logic run_ended = 1'b0;

   acq_top UUT (
      .clk             (clk),
      .reset           (reset),
      .ext_trig        (ext_trig),
      .start           (start),
      .stop            (stop),
      .capture_len     (capture_len),
      .sample_period   (sample_period),
      .dsample0_period (dsample0_period),
      .dsample1_period (dsample1_period),
      .dsample2_period (dsample2_period),
      .adc_data        (adc_data),
      .sample_out      (sample_out),
      .busy            (busy),
      .done            (done),
      .dec0_data       (dec0_data),
      .dec1_data       (dec1_data),
      .dec2_data       (dec2_data),
      .dec0_valid      (dec0_valid),
      .dec1_valid      (dec1_valid),
      .dec2_valid      (dec2_valid)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #4 clk = ~clk;
      end
   end

   // Watchdog
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= `ACQ_TIMEOUT_CYCLES) begin
         $display("Timeout: the capture runs did not finish within %0d cycles",
                  `ACQ_TIMEOUT_CYCLES);
         $display("ERRORS FOUND");
         run_ended = 1'b1;
         $finish;
      end
   end

   function automatic int rand_between(input int lo, input int hi);
      return lo + int'($urandom % 32'(hi - lo + 1));
   endfunction

   task automatic compare_value(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
      end
   endtask

   // One clock edge of the reference model, inputs as seen before the edge
   task automatic model_step();
      logic m_tick;
      logic m_restart;
      logic m_stb [NUM_CH];
      int   m_sum [NUM_CH];
      int   dper [NUM_CH];
      int   per_now;
      int   nxt_base;
      int   ch;

      m_tick    = (exp_state == st_run) && ext_trig;  // Trigger gated by run
      m_restart = (exp_state == st_restart);
      per_now   = int'(sample_period);
      dper[0]   = int'(dsample0_period);
      dper[1]   = int'(dsample1_period);
      dper[2]   = int'(dsample2_period);
      for (ch = 0; ch < NUM_CH; ch++) begin
         m_stb[ch] = exp_sample && (exp_ds[ch] == 1);
         m_sum[ch] = exp_acc[ch] + int'(adc_data);
      end

      if (reset) begin
         exp_state  = st_idle;
         exp_cnt    = 0;
         exp_done   = 1'b0;
         exp_per_r  = 0;
         exp_base   = 0;
         exp_sample = 1'b0;
         for (ch = 0; ch < NUM_CH; ch++) begin
            exp_ds[ch]    = 1;
            exp_acc[ch]   = 0;
            exp_data[ch]  = 0;
            exp_valid[ch] = 1'b0;
         end
      end else begin
         // Accumulators, a dump on the restart cycle is lost
         for (ch = 0; ch < NUM_CH; ch++) begin
            if (m_restart) begin
               exp_acc[ch]   = 0;
               exp_valid[ch] = 1'b0;
            end else begin
               exp_valid[ch] = m_stb[ch];
               if (m_stb[ch]) begin
                  exp_data[ch] = m_sum[ch];
                  exp_acc[ch]  = 0;
               end else if (exp_sample) begin
                  exp_acc[ch] = m_sum[ch];
               end
            end
         end

         for (ch = 0; ch < NUM_CH; ch++) begin
            if (m_restart) begin
               exp_ds[ch] = 1;
            end else if (exp_sample) begin
               exp_ds[ch] = (exp_ds[ch] == 1) ? dper[ch] : exp_ds[ch] - 1;
            end
         end

         exp_done = 1'b0;
         case (exp_state)
            st_idle: begin
               if (start) begin
                  exp_state = st_restart;
               end
            end
            st_restart: begin
               exp_cnt   = 0;
               exp_state = st_run;
            end
            st_run: begin
               if (stop || (exp_sample && (exp_cnt + 1 == int'(capture_len)))) begin
                  exp_state = st_idle;
                  exp_done  = 1'b1;
               end
               if (exp_sample) begin
                  exp_cnt++;
               end
            end
            default: begin
               exp_state = st_idle;
            end
         endcase

         // Base timer last, everything above used the old sample_out
         if (m_restart) begin
            exp_per_r  = 0;
            exp_base   = 0;
            exp_sample = 1'b0;
         end else if (m_tick) begin
            if ((per_now != exp_per_r) && (exp_base != 0)) begin
               nxt_base = 0;
            end else if (exp_base == per_now - 1) begin
               nxt_base = 0;
            end else begin
               nxt_base = exp_base + 1;
            end
            exp_sample = (exp_base == 0);
            exp_per_r  = per_now;
            exp_base   = nxt_base;
         end
      end
   endtask

   task automatic check_outputs();
      compare_value("sample_out", 32'(sample_out), 32'(exp_sample));
      compare_value("busy", 32'(busy), 32'(exp_state == st_run));
      compare_value("done", 32'(done), 32'(exp_done));
      compare_value("dec0_valid", 32'(dec0_valid), 32'(exp_valid[0]));
      compare_value("dec1_valid", 32'(dec1_valid), 32'(exp_valid[1]));
      compare_value("dec2_valid", 32'(dec2_valid), 32'(exp_valid[2]));
      compare_value("dec0_data", 32'(dec0_data), exp_data[0]);
      compare_value("dec1_data", 32'(dec1_data), exp_data[1]);
      compare_value("dec2_data", 32'(dec2_data), exp_data[2]);
   endtask

   // Returns on the falling edge, ready for the next inputs
   task automatic step_cycle();
      @(posedge clk);
      model_step();
      @(negedge clk);
      check_outputs();
   endtask

   task automatic drive_random_inputs();
      ext_trig = ($urandom % 4) != 0;  // About 75% high
      adc_data = adc_t'($urandom);
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      start = 1'b0;
      stop  = 1'b0;
      repeat (RESET_CYCLES) begin
         drive_random_inputs();
         step_cycle();
      end
      reset = 1'b0;
   endtask

   task automatic choose_settings(input int run_idx);
      if (run_idx == 0) begin
         sample_period = period_t'(1);
      end else if (run_idx == 1) begin
         sample_period = period_t'(12);
      end else begin
         sample_period = period_t'(rand_between(1, 12));
      end
      dsample0_period = dperiod_t'(rand_between(1, 8));
      dsample1_period = dperiod_t'(rand_between(1, 8));
      dsample2_period = dperiod_t'(rand_between(1, 8));
      capture_len     = count_t'(rand_between(4, 60));
   endtask

   task automatic capture_run(input int run_idx);
      int   samples_seen;
      int   iter;
      int   stop_at;
      int   start_at;
      int   change_at;
      logic stop_sent;

      samples_seen = 0;
      iter         = 0;
      stop_sent    = 1'b0;
      stop_at      = (rand_between(0, 3) == 0) ? rand_between(3, 60) : -1;
      start_at     = (rand_between(0, 2) == 0) ? rand_between(2, 20) : -1;
      change_at    = (rand_between(0, 2) == 0) ? rand_between(3, 40) : -1;

      choose_settings(run_idx);
      drive_random_inputs();
      start = 1'b1;
      step_cycle();
      start = 1'b0;
      compare_value("busy", 32'(busy), 32'd0);  // Still in restart

      while (done !== 1'b1) begin
         drive_random_inputs();
         stop  = (iter == stop_at);
         start = (iter == start_at);   // Ignored while running
         if (iter == stop_at) begin
            stop_sent = 1'b1;
         end
         if (iter == change_at) begin
            sample_period = period_t'(rand_between(1, 12));
         end
         step_cycle();
         if (iter == 0) begin
            compare_value("busy", 32'(busy), 32'd1);  // Second cycle after start
         end
         if (busy && sample_out) begin
            samples_seen++;
         end
         iter++;
      end
      stop  = 1'b0;
      start = 1'b0;

      if (!stop_sent) begin
         compare_value("samples per capture", 32'(samples_seen), 32'(capture_len));
      end
   endtask

   initial begin
      int run;

      void'($urandom(32'h27f9969e));
      reset           = 1'b1;
      ext_trig        = 1'b0;
      start           = 1'b0;
      stop            = 1'b0;
      capture_len     = count_t'(8);
      sample_period   = period_t'(4);
      dsample0_period = dperiod_t'(2);
      dsample1_period = dperiod_t'(3);
      dsample2_period = dperiod_t'(4);
      adc_data        = '0;

      apply_reset();
      for (run = 0; run < NUM_RUNS; run++) begin
         if (run == NUM_RUNS / 2) begin
            apply_reset();  // Reset with partial sums pending
         end
         capture_run(run);
         repeat (rand_between(2, 6)) begin
            drive_random_inputs();
            step_cycle();
         end
      end

      run_ended = 1'b1;
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   final begin
      if (!run_ended) begin
         $display("The simulation stopped before the test sequence completed");
         $display("ERRORS FOUND");
      end
   end

endmodule

/* acq_properties.sv */
module acq_properties (
   input logic clk,
   input logic reset,
   input logic restart,
   input logic sample_out,
   input logic done,
   input logic dsample0_stb,
   input logic dsample1_stb,
   input logic dsample2_stb,
   input logic dec0_valid,
   input logic dec1_valid,
   input logic dec2_valid
);

   timeunit 1ns;
   timeprecision 1ps;

   // End of capture lasts one cycle
   assert property (@(posedge clk) disable iff (reset) done |=> !done)
      else $error("done held high for more than one cycle");

   // Strobes only mark base samples
   assert property (@(posedge clk) disable iff (reset) dsample0_stb |-> sample_out)
      else $error("dsample0_stb high without sample_out");
   assert property (@(posedge clk) disable iff (reset) dsample1_stb |-> sample_out)
      else $error("dsample1_stb high without sample_out");
   assert property (@(posedge clk) disable iff (reset) dsample2_stb |-> sample_out)
      else $error("dsample2_stb high without sample_out");

   // One cycle from strobe to valid
   assert property (@(posedge clk) disable iff (reset)
                    dec0_valid == $past(dsample0_stb && !restart && !reset))
      else $error("dec0_valid does not follow dsample0_stb by one cycle");
   assert property (@(posedge clk) disable iff (reset)
                    dec1_valid == $past(dsample1_stb && !restart && !reset))
      else $error("dec1_valid does not follow dsample1_stb by one cycle");
   assert property (@(posedge clk) disable iff (reset)
                    dec2_valid == $past(dsample2_stb && !restart && !reset))
      else $error("dec2_valid does not follow dsample2_stb by one cycle");

   assert property (@(posedge clk) disable iff (reset) restart |=> !restart)
      else $error("restart high on two consecutive cycles");

endmodule

bind acq_top acq_properties u_properties (
   .clk          (clk),
   .reset        (reset),
   .restart      (restart),
   .sample_out   (sample_out),
   .done         (done),
   .dsample0_stb (dsample0_stb),
   .dsample1_stb (dsample1_stb),
   .dsample2_stb (dsample2_stb),
   .dec0_valid   (dec0_valid),
   .dec1_valid   (dec1_valid),
   .dec2_valid   (dec2_valid)
);

/* acq_top.sv */
`include "acq_consts.svh"

module acq_top
   import acq_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     ext_trig,
   input  logic     start,
   input  logic     stop,
   input  count_t   capture_len,
   input  period_t  sample_period,
   input  dperiod_t dsample0_period,
   input  dperiod_t dsample1_period,
   input  dperiod_t dsample2_period,
   input  adc_t     adc_data,
   output logic     sample_out,
   output logic     busy,
   output logic     done,
   output sum_t     dec0_data,
   output sum_t     dec1_data,
   output sum_t     dec2_data,
   output logic     dec0_valid,
   output logic     dec1_valid,
   output logic     dec2_valid
);

   logic tick;          // Gated trigger
   logic restart;
   logic dsample0_stb;
   logic dsample1_stb;
   logic dsample2_stb;

   acq_control u_control (
      .clk         (clk),
      .reset       (reset),
      .ext_trig    (ext_trig),
      .start       (start),
      .stop        (stop),
      .capture_len (capture_len),
      .sample_out  (sample_out),
      .tick        (tick),
      .restart     (restart),
      .busy        (busy),
      .done        (done)
   );

   multi_sampler u_sampler (
      .clk             (clk),
      .reset           (reset),
      .tick            (tick),
      .restart         (restart),
      .sample_period   (sample_period),
      .dsample0_period (dsample0_period),
      .dsample1_period (dsample1_period),
      .dsample2_period (dsample2_period),
      .sample_out      (sample_out),
      .dsample0_stb    (dsample0_stb),
      .dsample1_stb    (dsample1_stb),
      .dsample2_stb    (dsample2_stb)
   );

   // One accumulator per decimation channel
   decim_accum u_dec0 (
      .clk         (clk),
      .reset       (reset),
      .restart     (restart),
      .sample_out  (sample_out),
      .dsample_stb (dsample0_stb),
      .adc_data    (adc_data),
      .dec_data    (dec0_data),
      .dec_valid   (dec0_valid)
   );

   decim_accum u_dec1 (
      .clk         (clk),
      .reset       (reset),
      .restart     (restart),
      .sample_out  (sample_out),
      .dsample_stb (dsample1_stb),
      .adc_data    (adc_data),
      .dec_data    (dec1_data),
      .dec_valid   (dec1_valid)
   );

   decim_accum u_dec2 (
      .clk         (clk),
      .reset       (reset),
      .restart     (restart),
      .sample_out  (sample_out),
      .dsample_stb (dsample2_stb),
      .adc_data    (adc_data),
      .dec_data    (dec2_data),
      .dec_valid   (dec2_valid)
   );

endmodule

/* decim_accum.sv */
`include "acq_consts.svh"

module decim_accum
   import acq_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic restart,      // Drops the partial sum
   input  logic sample_out,   // Base sample strobe
   input  logic dsample_stb,  // End of decimation interval
   input  adc_t adc_data,
   output sum_t dec_data,
   output logic dec_valid
);

   sum_t acc;
   sum_t adc_ext;
   sum_t interval_sum;
   logic dump;

   assign adc_ext      = `SUM_WI'(adc_data);  // Zero extend, words are unsigned
   assign interval_sum = acc + adc_ext;
   assign dump         = sample_out && dsample_stb;

   // Running sum and valid pulse
   always_ff @(posedge clk) begin
      if (reset || restart) begin
         acc       <= '0;
         dec_valid <= 1'b0;
      end else begin
         dec_valid <= dump;
         if (sample_out) begin
            if (dsample_stb) begin
               acc <= '0;  // Next interval starts empty
            end else begin
               acc <= interval_sum;
            end
         end
      end
   end

   // Output word, held between dumps
   always_ff @(posedge clk) begin
      if (reset) begin
         dec_data <= '0;
      end else if (dump && !restart) begin
         dec_data <= interval_sum;  // Includes the word of the strobe cycle
      end
   end

endmodule

/* acq_control.sv */
`include "acq_consts.svh"

module acq_control
   import acq_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  logic   ext_trig,
   input  logic   start,
   input  logic   stop,
   input  count_t capture_len,   // Base samples per capture run
   input  logic   sample_out,
   output logic   tick,
   output logic   restart,
   output logic   busy,
   output logic   done
);

   ctrl_state_t state;
   count_t      sample_cnt;
   count_t      next_cnt;
   logic        last_sample;
   logic        end_run;

   assign next_cnt    = sample_cnt + `CAPTURE_WI'(1);
   assign last_sample = sample_out && (next_cnt == capture_len);  // Final sample of the run
   assign end_run     = stop || last_sample;

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= st_idle;
         sample_cnt <= '0;
         done       <= 1'b0;
      end else begin
         done <= 1'b0;
         unique case (state)
            st_idle: begin
               if (start) begin
                  state <= st_restart;
               end
            end
            st_restart: begin
               sample_cnt <= '0;
               state      <= st_run;
            end
            st_run: begin
               if (sample_out) begin
                  sample_cnt <= next_cnt;
               end
               // Either the programmed length or an early stop ends the run
               if (end_run) begin
                  state <= st_idle;
                  done  <= 1'b1;
               end
            end
            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

   // Trigger only reaches the timer while a run is active
   assign tick    = (state == st_run) && ext_trig;
   assign restart = (state == st_restart);
   assign busy    = (state == st_run);

endmodule

/* multi_sampler.sv */
`include "acq_consts.svh"

module multi_sampler
   import acq_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     tick,             // Qualified clock enable
   input  logic     restart,          // Clears all counters
   input  period_t  sample_period,
   input  dperiod_t dsample0_period,
   input  dperiod_t dsample1_period,
   input  dperiod_t dsample2_period,
   output logic     sample_out,
   output logic     dsample0_stb,
   output logic     dsample1_stb,
   output logic     dsample2_stb
);

   localparam int NUM_DS = 3;

   period_t    samp_per_r;            // Period seen at the previous tick
   period_t    base_count;
   logic       period_changed;
   logic       base_wrap;
   dperiod_t   ds_period [NUM_DS];
   dperiod_t   ds_count [NUM_DS];
   logic [NUM_DS-1:0] ds_stb;

   assign period_changed = (sample_period != samp_per_r) && (base_count != '0);
   assign base_wrap      = (base_count == period_t'(sample_period - 1'b1));

   // Base timing
   always_ff @(posedge clk) begin
      if (reset || restart) begin
         samp_per_r <= '0;
         base_count <= '0;
         sample_out <= 1'b0;
      end else if (tick) begin
         samp_per_r <= sample_period;

         // A new period mid-count restarts the count from zero
         if (period_changed) begin
            base_count <= '0;
         end else if (base_wrap) begin
            base_count <= '0;
         end else begin
            base_count <= base_count + 1'b1;
         end

         sample_out <= (base_count == '0);  // Held until the next tick
      end
   end

   assign ds_period[0] = dsample0_period;
   assign ds_period[1] = dsample1_period;
   assign ds_period[2] = dsample2_period;

   // Decimation down counters, one per channel
   for (genvar i = 0; i < NUM_DS; i++) begin : g_dsample
      always_ff @(posedge clk) begin
         if (reset || restart) begin
            ds_count[i] <= `DSAMPLE_WI'(1);  // First base sample fires the strobe
         end else if (sample_out) begin
            if (ds_count[i] == `DSAMPLE_WI'(1)) begin
               ds_count[i] <= ds_period[i];
            end else begin
               ds_count[i] <= ds_count[i] - 1'b1;
            end
         end
      end

      // Qualified by sample_out so each strobe marks exactly one base sample
      assign ds_stb[i] = sample_out && (ds_count[i] == `DSAMPLE_WI'(1));
   end

   assign dsample0_stb = ds_stb[0];
   assign dsample1_stb = ds_stb[1];
   assign dsample2_stb = ds_stb[2];

endmodule

/* acq_pkg.sv */
`include "acq_consts.svh"

package acq_pkg;

   // Base sample period in enabled clock cycles
   typedef logic [`SAMPLE_PERIOD_WI-1:0] period_t;

   // Decimation ratio in base samples
   typedef logic [`DSAMPLE_WI-1:0] dperiod_t;

   // Unsigned ADC word
   typedef logic [`ADC_WI-1:0] adc_t;

   // Accumulated sum over one decimation interval
   typedef logic [`SUM_WI-1:0] sum_t;

   // Capture length and sample count
   typedef logic [`CAPTURE_WI-1:0] count_t;

   // Capture control states
   typedef enum logic [1:0] {
      st_idle,     // Waiting for start
      st_restart,  // One cycle, clears timer and accumulators
      st_run       // Trigger passed through, samples counted
   } ctrl_state_t;

endpackage

/* acq_consts.svh */
`ifndef ACQ_CONSTS_SVH
`define ACQ_CONSTS_SVH

// Base sample period and base counter
`define SAMPLE_PERIOD_WI 8

// Decimation ratio and down counters
`define DSAMPLE_WI 6

// Raw ADC word, unsigned
`define ADC_WI 12

// Holds 63 full-scale ADC words without overflow
`define SUM_WI 20

// Capture length and sample counter
`define CAPTURE_WI 12

// Simulation watchdog in clock cycles
// 20 runs, each at most 60 samples of period 12 with trigger gaps, plus slack
`define ACQ_TIMEOUT_CYCLES (20 * (60 * 12 * 2 + 50))

`endif
